//--- hw/mips_id_pkg.sv
package mips_id_pkg;

  // widths
  localparam int word_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int op_w       = 6;
  localparam int funct_w    = 6;
  localparam int reg_count  = 32;

  localparam logic [reg_addr_w-1:0] ra_reg = 5'd31; // return address

  // primary opcodes, inst[31:26]
  localparam logic [op_w-1:0] op_special  = 6'b000000;
  localparam logic [op_w-1:0] op_regimm   = 6'b000001;
  localparam logic [op_w-1:0] op_j        = 6'b000010;
  localparam logic [op_w-1:0] op_jal      = 6'b000011;
  localparam logic [op_w-1:0] op_beq      = 6'b000100;
  localparam logic [op_w-1:0] op_bne      = 6'b000101;
  localparam logic [op_w-1:0] op_blez     = 6'b000110;
  localparam logic [op_w-1:0] op_bgtz     = 6'b000111;

  // immediate alu ops
  localparam logic [op_w-1:0] op_addi     = 6'b001000;
  localparam logic [op_w-1:0] op_addiu    = 6'b001001;
  localparam logic [op_w-1:0] op_andi     = 6'b001100;
  localparam logic [op_w-1:0] op_ori      = 6'b001101;
  localparam logic [op_w-1:0] op_xori     = 6'b001110;
  localparam logic [op_w-1:0] op_lui      = 6'b001111;

  localparam logic [op_w-1:0] op_special2 = 6'b011100;

  // loads
  localparam logic [op_w-1:0] op_lb       = 6'b100000;
  localparam logic [op_w-1:0] op_lh       = 6'b100001;
  localparam logic [op_w-1:0] op_lwl      = 6'b100010;
  localparam logic [op_w-1:0] op_lw       = 6'b100011;
  localparam logic [op_w-1:0] op_lbu      = 6'b100100;
  localparam logic [op_w-1:0] op_lhu      = 6'b100101;
  localparam logic [op_w-1:0] op_lwr      = 6'b100110;

  // stores
  localparam logic [op_w-1:0] op_sb       = 6'b101000;
  localparam logic [op_w-1:0] op_sh       = 6'b101001;
  localparam logic [op_w-1:0] op_swl      = 6'b101010;
  localparam logic [op_w-1:0] op_sw       = 6'b101011;
  localparam logic [op_w-1:0] op_swr      = 6'b101110;

  // funct codes, inst[5:0]
  localparam logic [funct_w-1:0] funct_jr    = 6'b001000;
  localparam logic [funct_w-1:0] funct_mult  = 6'b011000;
  localparam logic [funct_w-1:0] funct_multu = 6'b011001;
  localparam logic [funct_w-1:0] funct_div   = 6'b011010;
  localparam logic [funct_w-1:0] funct_divu  = 6'b011011;
  localparam logic [funct_w-1:0] funct_mul   = 6'b000010; // special2 mul

  // regimm link variants, carried in rt
  localparam logic [reg_addr_w-1:0] rt_bltzal = 5'b10000;
  localparam logic [reg_addr_w-1:0] rt_bgezal = 5'b10001;

endpackage

//--- hw/inst_accept.sv
module inst_accept (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_req,
  input  logic [mips_id_pkg::word_w-1:0] in_inst,
  output logic                           in_ack,
  output logic [mips_id_pkg::word_w-1:0] inst,
  output logic                           load,
  input  logic                           done
);

  logic slot_full;
  logic accept;

  // take a new word only when idle on both sides
  assign accept = in_req && !in_ack && !slot_full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_ack    <= 1'b0;
      load      <= 1'b0;
      slot_full <= 1'b0;
    end else begin
      load <= accept; // single cycle capture pulse

      if (accept) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0; // return to zero once req drops
      end

      if (accept) begin
        slot_full <= 1'b1;
      end else if (done) begin
        slot_full <= 1'b0;
      end
    end
  end

  // held word, stays put until the slot is freed
  always_ff @(posedge clk) begin
    if (accept) begin
      inst <= in_inst;
    end
  end

  // sender keeps data steady until acknowledged
  a_inst_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (in_req && !in_ack) |=> (!in_req || $stable(in_inst)));

  // no req withdrawal before ack
  a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    (in_req && !in_ack) |=> (in_req || in_ack));

  // issue side only frees a slot that was filled
  a_done_full: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> slot_full);

endmodule

//--- hw/reg_gen.sv
module reg_gen (
  input  logic [mips_id_pkg::word_w-1:0]     inst,
  output logic                               rd_en_1,
  output logic                               rd_en_2,
  output logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_1,
  output logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_2,
  output logic                               wr_en,
  output logic [mips_id_pkg::reg_addr_w-1:0] wr_addr
);

  logic [mips_id_pkg::op_w-1:0]       op;
  logic [mips_id_pkg::reg_addr_w-1:0] rs;
  logic [mips_id_pkg::reg_addr_w-1:0] rt;
  logic [mips_id_pkg::reg_addr_w-1:0] rd;
  logic [mips_id_pkg::funct_w-1:0]    funct;

  logic                               dst_on;  // instruction has a destination
  logic [mips_id_pkg::reg_addr_w-1:0] dst;

  // field split
  assign op    = inst[31:26];
  assign rs    = inst[25:21];
  assign rt    = inst[20:16];
  assign rd    = inst[15:11];
  assign funct = inst[5:0];

  // source registers
  always_comb begin
    rd_en_1   = 1'b0;
    rd_en_2   = 1'b0;
    rd_addr_1 = '0;
    rd_addr_2 = '0;
    case (op)
      mips_id_pkg::op_addi, mips_id_pkg::op_addiu, mips_id_pkg::op_andi,
      mips_id_pkg::op_ori, mips_id_pkg::op_xori,
      mips_id_pkg::op_lb, mips_id_pkg::op_lh, mips_id_pkg::op_lw,
      mips_id_pkg::op_lbu, mips_id_pkg::op_lhu: begin
        rd_en_1   = 1'b1; // base or alu source only
        rd_addr_1 = rs;
      end
      mips_id_pkg::op_beq, mips_id_pkg::op_bne, mips_id_pkg::op_blez,
      mips_id_pkg::op_bgtz, mips_id_pkg::op_regimm,
      mips_id_pkg::op_sb, mips_id_pkg::op_sh, mips_id_pkg::op_sw,
      mips_id_pkg::op_lwl, mips_id_pkg::op_lwr,
      mips_id_pkg::op_swl, mips_id_pkg::op_swr,
      mips_id_pkg::op_special, mips_id_pkg::op_special2: begin
        rd_en_1   = 1'b1;
        rd_en_2   = 1'b1;
        rd_addr_1 = rs;
        rd_addr_2 = rt;
      end
      mips_id_pkg::op_j, mips_id_pkg::op_jal, mips_id_pkg::op_lui: begin
        // no register source
      end
      default: ;
    endcase
  end

  // destination register
  always_comb begin
    dst_on = 1'b0;
    dst    = '0;
    case (op)
      mips_id_pkg::op_addi, mips_id_pkg::op_addiu, mips_id_pkg::op_andi,
      mips_id_pkg::op_ori, mips_id_pkg::op_xori, mips_id_pkg::op_lui,
      mips_id_pkg::op_lb, mips_id_pkg::op_lh, mips_id_pkg::op_lw,
      mips_id_pkg::op_lbu, mips_id_pkg::op_lhu,
      mips_id_pkg::op_lwl, mips_id_pkg::op_lwr: begin
        dst_on = 1'b1; // i-type result into rt
        dst    = rt;
      end
      mips_id_pkg::op_special, mips_id_pkg::op_special2: begin
        case (funct)
          mips_id_pkg::funct_mult, mips_id_pkg::funct_multu,
          mips_id_pkg::funct_div, mips_id_pkg::funct_divu,
          mips_id_pkg::funct_jr: begin
            dst_on = 1'b0; // hi/lo or jump, no gpr result
          end
          mips_id_pkg::funct_mul: begin
            dst_on = 1'b1;
            dst    = rd;
          end
          default: begin
            dst_on = 1'b1;
            dst    = rd;
          end
        endcase
      end
      mips_id_pkg::op_jal: begin
        dst_on = 1'b1;
        dst    = mips_id_pkg::ra_reg;
      end
      mips_id_pkg::op_regimm: begin
        if (rt == mips_id_pkg::rt_bltzal || rt == mips_id_pkg::rt_bgezal) begin
          dst_on = 1'b1;
          dst    = mips_id_pkg::ra_reg;
        end
      end
      mips_id_pkg::op_j, mips_id_pkg::op_beq, mips_id_pkg::op_bne,
      mips_id_pkg::op_blez, mips_id_pkg::op_bgtz,
      mips_id_pkg::op_sb, mips_id_pkg::op_sh, mips_id_pkg::op_sw,
      mips_id_pkg::op_swl, mips_id_pkg::op_swr: begin
        dst_on = 1'b0;
      end
      default: ;
    endcase
  end

  // $zero is never a real destination
  assign wr_en   = dst_on && (dst != '0);
  assign wr_addr = wr_en ? dst : '0;

endmodule

//--- hw/reg_file.sv
module reg_file (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_1,
  input  logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_2,
  output logic [mips_id_pkg::word_w-1:0]     rd_data_1,
  output logic [mips_id_pkg::word_w-1:0]     rd_data_2,
  input  logic                               wb_en,
  input  logic [mips_id_pkg::reg_addr_w-1:0] wb_addr,
  input  logic [mips_id_pkg::word_w-1:0]     wb_data
);

  logic [mips_id_pkg::word_w-1:0] regs [mips_id_pkg::reg_count];

  logic wr_ok;

  assign wr_ok = wb_en && (wb_addr != '0); // writes to $zero dropped

  // whole array clears on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < mips_id_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational reads, $zero forced
  always_comb begin
    if (rd_addr_1 == '0) begin
      rd_data_1 = '0;
    end else begin
      rd_data_1 = regs[rd_addr_1];
    end
  end

  always_comb begin
    if (rd_addr_2 == '0) begin
      rd_data_2 = '0;
    end else begin
      rd_data_2 = regs[rd_addr_2];
    end
  end

endmodule

//--- hw/operand_issue.sv
module operand_issue (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               load,
  output logic                               done,
  input  logic                               rd_en_1,
  input  logic                               rd_en_2,
  input  logic [mips_id_pkg::word_w-1:0]     rd_data_1,
  input  logic [mips_id_pkg::word_w-1:0]     rd_data_2,
  input  logic                               wr_en,
  input  logic [mips_id_pkg::reg_addr_w-1:0] wr_addr,
  output logic                               out_req,
  input  logic                               out_ack,
  output logic [mips_id_pkg::word_w-1:0]     op_a,
  output logic [mips_id_pkg::word_w-1:0]     op_b,
  output logic                               out_rd_en_1,
  output logic                               out_rd_en_2,
  output logic                               out_wr_en,
  output logic [mips_id_pkg::reg_addr_w-1:0] out_wr_addr
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,     // out_req high, waiting for ack
    st_release  // waiting for ack to return low
  } state_t;

  state_t state;

  assign out_req = (state == st_req);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle:    if (load) state <= st_req;
        st_req:     if (out_ack) state <= st_release;
        st_release: begin
          if (!out_ack) begin
            state <= st_idle;
            done  <= 1'b1; // handshake closed, free the slot
          end
        end
        default:    state <= st_idle;
      endcase
    end
  end

  // operand set, frozen while out_req is up
  always_ff @(posedge clk) begin
    if (load && state == st_idle) begin
      op_a        <= rd_en_1 ? rd_data_1 : '0;
      op_b        <= rd_en_2 ? rd_data_2 : '0;
      out_rd_en_1 <= rd_en_1;
      out_rd_en_2 <= rd_en_2;
      out_wr_en   <= wr_en;
      out_wr_addr <= wr_addr;
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    (out_req && !out_ack) |=> out_req);

endmodule

//--- hw/mips_id_top.sv
module mips_id_top (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               in_req,
  input  logic [mips_id_pkg::word_w-1:0]     in_inst,
  output logic                               in_ack,
  input  logic                               wb_en,
  input  logic [mips_id_pkg::reg_addr_w-1:0] wb_addr,
  input  logic [mips_id_pkg::word_w-1:0]     wb_data,
  output logic                               out_req,
  input  logic                               out_ack,
  output logic [mips_id_pkg::word_w-1:0]     op_a,
  output logic [mips_id_pkg::word_w-1:0]     op_b,
  output logic                               out_rd_en_1,
  output logic                               out_rd_en_2,
  output logic                               out_wr_en,
  output logic [mips_id_pkg::reg_addr_w-1:0] out_wr_addr
);

  logic [mips_id_pkg::word_w-1:0]     inst;
  logic                               load;
  logic                               done;
  logic                               rd_en_1;
  logic                               rd_en_2;
  logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_1;
  logic [mips_id_pkg::reg_addr_w-1:0] rd_addr_2;
  logic [mips_id_pkg::word_w-1:0]     rd_data_1;
  logic [mips_id_pkg::word_w-1:0]     rd_data_2;
  logic                               wr_en;
  logic [mips_id_pkg::reg_addr_w-1:0] wr_addr;

  inst_accept i_inst_accept (
    .clk, .arst_n, .in_req, .in_inst, .in_ack, .inst, .load, .done
  );

  // decode straight off the held slot
  reg_gen i_reg_gen (
    .inst, .rd_en_1, .rd_en_2, .rd_addr_1, .rd_addr_2, .wr_en, .wr_addr
  );

  reg_file i_reg_file (
    .clk, .arst_n,
    .rd_addr_1, .rd_addr_2, .rd_data_1, .rd_data_2,
    .wb_en, .wb_addr, .wb_data
  );

  operand_issue i_operand_issue (
    .clk, .arst_n, .load, .done,
    .rd_en_1, .rd_en_2, .rd_data_1, .rd_data_2, .wr_en, .wr_addr,
    .out_req, .out_ack, .op_a, .op_b,
    .out_rd_en_1, .out_rd_en_2, .out_wr_en, .out_wr_addr
  );

endmodule

//--- test/tb_mips_id.sv
module tb_mips_id;

  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [5:0] funct;
    logic       en_1;  // expected read enables
    logic       en_2;
    logic       wen;
    logic [4:0] waddr;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        in_req;
  logic [31:0] in_inst;
  logic        in_ack;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        out_req;
  logic        out_ack;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        out_rd_en_1;
  logic        out_rd_en_2;
  logic        out_wr_en;
  logic [4:0]  out_wr_addr;

  row_t        rows [$];
  logic [31:0] shadow [32];  // expected register contents
  int          completed;    // output handshakes closed so far
  int          cycles;
  int          limit;

  logic        prev_in_req;
  logic        prev_in_ack;
  logic        prev_out_req;
  logic        prev_out_ack;
  logic [31:0] prev_op_a;
  logic [31:0] prev_op_b;
  logic [7:0]  prev_flags;

  mips_id_top i_mips_id_top (
    .clk, .arst_n, .in_req, .in_inst, .in_ack,
    .wb_en, .wb_addr, .wb_data,
    .out_req, .out_ack, .op_a, .op_b,
    .out_rd_en_1, .out_rd_en_2, .out_wr_en, .out_wr_addr
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic add_row(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [4:0] rd, input logic [5:0] funct, input logic en_1,
                         input logic en_2, input logic wen, input logic [4:0] waddr);
    rows.push_back({op, rs, rt, rd, funct, en_1, en_2, wen, waddr});
  endtask

  function automatic logic [31:0] build_word(input row_t row);
    return {row.op, row.rs, row.rt, row.rd, 5'd0, row.funct}; // shamt left 0
  endfunction

  task automatic build_table();
    // row 0 runs before write-back, so all operands read back as 0
    add_row(mips_id_pkg::op_special, 5'd31, 5'd1, 5'd2, 6'b100001, 1, 1, 1, 5'd2);
    add_row(mips_id_pkg::op_addi, 5'd1, 5'd2, 5'd0, 6'd0, 1, 0, 1, 5'd2);
    add_row(mips_id_pkg::op_addiu, 5'd5, 5'd0, 5'd3, 6'd7, 1, 0, 0, 5'd0); // rt is $zero
    add_row(mips_id_pkg::op_addi, 5'd0, 5'd6, 5'd0, 6'd0, 1, 0, 1, 5'd6);
    add_row(mips_id_pkg::op_andi, 5'd7, 5'd8, 5'd1, 6'd3, 1, 0, 1, 5'd8);
    add_row(mips_id_pkg::op_ori, 5'd9, 5'd10, 5'd0, 6'd0, 1, 0, 1, 5'd10);
    add_row(mips_id_pkg::op_xori, 5'd11, 5'd12, 5'd4, 6'd9, 1, 0, 1, 5'd12);
    add_row(mips_id_pkg::op_lui, 5'd13, 5'd14, 5'd0, 6'd0, 0, 0, 1, 5'd14);
    add_row(mips_id_pkg::op_lb, 5'd15, 5'd16, 5'd0, 6'd0, 1, 0, 1, 5'd16);
    add_row(mips_id_pkg::op_lh, 5'd17, 5'd18, 5'd0, 6'd4, 1, 0, 1, 5'd18);
    add_row(mips_id_pkg::op_lw, 5'd19, 5'd20, 5'd0, 6'd8, 1, 0, 1, 5'd20);
    add_row(mips_id_pkg::op_lbu, 5'd21, 5'd22, 5'd0, 6'd1, 1, 0, 1, 5'd22);
    add_row(mips_id_pkg::op_lhu, 5'd23, 5'd24, 5'd0, 6'd2, 1, 0, 1, 5'd24);
    add_row(mips_id_pkg::op_lwl, 5'd25, 5'd26, 5'd0, 6'd0, 1, 1, 1, 5'd26); // merge load
    add_row(mips_id_pkg::op_lwr, 5'd27, 5'd28, 5'd0, 6'd3, 1, 1, 1, 5'd28);
    add_row(mips_id_pkg::op_sb, 5'd29, 5'd30, 5'd0, 6'd0, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_sh, 5'd3, 5'd4, 5'd0, 6'd2, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_sw, 5'd5, 5'd6, 5'd0, 6'd4, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_swl, 5'd7, 5'd8, 5'd0, 6'd0, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_swr, 5'd9, 5'd10, 5'd0, 6'd3, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_beq, 5'd11, 5'd12, 5'd1, 6'd0, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_bne, 5'd13, 5'd14, 5'd0, 6'd5, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_blez, 5'd15, 5'd0, 5'd0, 6'd0, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_bgtz, 5'd16, 5'd0, 5'd2, 6'd0, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_regimm, 5'd17, mips_id_pkg::rt_bltzal, 5'd0, 6'd0, 1, 1, 1, 5'd31);
    add_row(mips_id_pkg::op_regimm, 5'd18, mips_id_pkg::rt_bgezal, 5'd0, 6'd0, 1, 1, 1, 5'd31);
    add_row(mips_id_pkg::op_regimm, 5'd19, 5'd1, 5'd0, 6'd0, 1, 1, 0, 5'd0); // plain bgez
    add_row(mips_id_pkg::op_j, 5'd20, 5'd21, 5'd3, 6'd1, 0, 0, 0, 5'd0);
    add_row(mips_id_pkg::op_jal, 5'd22, 5'd23, 5'd0, 6'd0, 0, 0, 1, 5'd31);
    add_row(mips_id_pkg::op_special, 5'd22, 5'd23, 5'd24, mips_id_pkg::funct_mult,
            1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special, 5'd1, 5'd2, 5'd3, mips_id_pkg::funct_multu,
            1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special, 5'd4, 5'd5, 5'd6, mips_id_pkg::funct_div, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special, 5'd7, 5'd8, 5'd9, mips_id_pkg::funct_divu, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special, 5'd31, 5'd0, 5'd0, mips_id_pkg::funct_jr, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special2, 5'd25, 5'd26, 5'd27, mips_id_pkg::funct_mul,
            1, 1, 1, 5'd27);
    add_row(mips_id_pkg::op_special, 5'd10, 5'd11, 5'd0, 6'b100101, 1, 1, 0, 5'd0);
    add_row(mips_id_pkg::op_special, 5'd0, 5'd0, 5'd30, 6'b100011, 1, 1, 1, 5'd30);
    add_row(6'b111111, 5'd12, 5'd13, 5'd14, 6'd0, 0, 0, 0, 5'd0); // unknown opcodes
    add_row(6'b010000, 5'd15, 5'd16, 5'd17, 6'd0, 0, 0, 0, 5'd0);
  endtask

  // input side, one instruction at a time
  task automatic send_rows(input int first, input int last);
    for (int r = first; r <= last; r++) begin
      in_inst = build_word(rows[r]);
      in_req  = 1'b1;
      do begin
        @(posedge clk);
        #1;
      end while (!in_ack);
      // earlier instructions must all have left the output side
      check_value(completed, r, $sformatf("row %0d output handshakes done at accept", r));
      in_req = 1'b0;
      do begin
        @(posedge clk);
        #1;
      end while (in_ack);
    end
  endtask

  // output side with random ack delay
  task automatic receive_rows(input int first, input int last);
    row_t        row;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    int unsigned delay;
    for (int r = first; r <= last; r++) begin
      row   = rows[r];
      exp_a = row.en_1 ? shadow[row.rs] : 32'd0;
      exp_b = row.en_2 ? shadow[row.rt] : 32'd0;
      do begin
        @(posedge clk);
        #1;
      end while (!out_req);
      check_value(out_rd_en_1, row.en_1, $sformatf("row %0d read enable 1", r));
      check_value(out_rd_en_2, row.en_2, $sformatf("row %0d read enable 2", r));
      check_value(out_wr_en, row.wen, $sformatf("row %0d write enable", r));
      check_value(out_wr_addr, row.waddr, $sformatf("row %0d write address", r));
      check_value(op_a, exp_a, $sformatf("row %0d operand a", r));
      check_value(op_b, exp_b, $sformatf("row %0d operand b", r));
      delay = $urandom_range(20, 0);
      repeat (delay) begin
        @(posedge clk);
        #1;
      end
      out_ack = 1'b1;
      do begin
        @(posedge clk);
        #1;
      end while (out_req);
      out_ack = 1'b0;
      completed++;
    end
  endtask

  task automatic run_rows(input int first, input int last);
    fork
      send_rows(first, last);
      receive_rows(first, last);
    join
    repeat (4) @(posedge clk); // let done free the slot
    #1;
  endtask

  task automatic fill_regs();
    logic [31:0] value;
    for (int a = 0; a < 32; a++) begin
      value   = $urandom;
      wb_en   = 1'b1;
      wb_addr = a[4:0];
      wb_data = value;
      if (a != 0) begin
        shadow[a] = value; // write to $zero is dropped
      end
      @(posedge clk);
      #1;
    end
    wb_en = 1'b0;
  endtask

  // handshake order and output stability, sampled mid cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (in_ack && !prev_in_ack) begin
        check_value(prev_in_req, 1'b1, "in_ack rose without in_req");
      end
      if (!in_ack && prev_in_ack) begin
        check_value(prev_in_req, 1'b0, "in_ack fell before in_req fell");
      end
      if (!out_req && prev_out_req) begin
        check_value(prev_out_ack, 1'b1, "out_req fell without out_ack");
      end
      if (out_req && prev_out_req) begin
        check_value(op_a, prev_op_a, "op_a changed while out_req high");
        check_value(op_b, prev_op_b, "op_b changed while out_req high");
        check_value({out_rd_en_1, out_rd_en_2, out_wr_en, out_wr_addr}, prev_flags,
                    "decode outputs changed while out_req high");
      end
    end
    prev_in_req  = in_req;
    prev_in_ack  = in_ack;
    prev_out_req = out_req;
    prev_out_ack = out_ack;
    prev_op_a    = op_a;
    prev_op_b    = op_b;
    prev_flags   = {out_rd_en_1, out_rd_en_2, out_wr_en, out_wr_addr};
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run still busy after %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    arst_n    = 1'b0;
    in_req    = 1'b0;
    in_inst   = '0;
    wb_en     = 1'b0;
    wb_addr   = '0;
    wb_data   = '0;
    out_ack   = 1'b0;
    completed = 0;
    cycles    = 0;
    for (int a = 0; a < 32; a++) begin
      shadow[a] = '0;
    end
    void'($urandom(32'he891_c2de));
    build_table();
    limit = 40 * rows.size() + 100;

    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value(in_ack, 1'b0, "in_ack after reset");
    check_value(out_req, 1'b0, "out_req after reset");

    run_rows(0, 0); // register file still cleared
    fill_regs();
    run_rows(1, rows.size() - 1);
    check_value(completed, rows.size(), "instructions delivered");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- mips_id.f
hw/mips_id_pkg.sv
hw/inst_accept.sv
hw/reg_gen.sv
hw/reg_file.sv
hw/operand_issue.sv
hw/mips_id_top.sv
test/tb_mips_id.sv
